//--- compile.f
+incdir+test
hw/conv_pkg.sv
hw/kernel_regs.sv
hw/window_store.sv
hw/mac_pipe.sv
hw/result_store.sv
hw/conv_ctrl.sv
hw/conv_top.sv
test/tb_conv_top.sv

//--- hw/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl #(
    parameter int img_width  = 8,
    parameter int img_height = 8
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          start,
    output conv_pkg::tap_req_t req,
    output logic               busy
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    localparam logic [3:0] last_tap = 4'(conv_pkg::KTAPS - 1);
    localparam logic [3:0] last_col = 4'(img_width - 3);   // rightmost window column
    localparam logic [3:0] last_row = 4'(img_height - 3);  // bottom window row

    state_t     state;
    logic [3:0] tap_cnt;
    logic [3:0] col_cnt;
    logic [3:0] row_cnt;
    logic       tap_wrap;
    logic       col_wrap;
    logic       row_wrap;

    assign tap_wrap = (tap_cnt == last_tap);
    assign col_wrap = (col_cnt == last_col);
    assign row_wrap = (row_cnt == last_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            tap_cnt <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= RUN;
                        tap_cnt <= '0;
                        col_cnt <= '0;
                        row_cnt <= '0;
                    end
                end
                RUN: begin
                    // start is ignored here, the run in progress continues
                    if (!tap_wrap) begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end else begin
                        tap_cnt <= '0;
                        if (!col_wrap) begin
                            col_cnt <= col_cnt + 1'b1;
                        end else begin
                            col_cnt <= '0;
                            if (!row_wrap) begin
                                row_cnt <= row_cnt + 1'b1;
                            end else begin
                                state <= IDLE;  // final tap of final window
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one tap per cycle while running, no gaps between windows
    always_comb begin
        req.valid = (state == RUN);
        req.first = (tap_cnt == 4'd0);
        req.last  = tap_wrap;
        req.row   = row_cnt;
        req.col   = col_cnt;
        req.tap   = tap_cnt;
    end

    assign busy = (state == RUN);  // covers exactly the cycles that issue taps

endmodule

`default_nettype wire

//--- hw/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int KTAPS = 9;  // 3x3 window

    typedef logic signed [31:0] pixel_t;
    typedef logic signed [31:0] weight_t;
    typedef logic signed [31:0] acc_t;  // wraps at 32 bits

    // tap 0 is top-left, row-major
    typedef weight_t [KTAPS-1:0] kernel_t;

    typedef struct packed {
        logic       valid;
        logic       first;  // first tap of a window
        logic       last;   // last tap of a window
        logic [3:0] row;    // window top-left row
        logic [3:0] col;    // window top-left column
        logic [3:0] tap;    // 0 to 8
    } tap_req_t;

    typedef struct packed {
        logic    valid;
        logic    first;
        logic    last;
        pixel_t  pixel;
        weight_t weight;
    } mac_op_t;

    typedef struct packed {
        logic valid;
        acc_t sum;
    } acc_out_t;

endpackage

`default_nettype wire

//--- hw/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
    parameter  int img_width  = 8,
    parameter  int img_height = 8,
    localparam int pix_aw     = $clog2(img_width * img_height),
    localparam int res_aw     = $clog2((img_width - 2) * (img_height - 2))
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              pix_we,
    input  wire logic [pix_aw-1:0] pix_addr,
    input  wire conv_pkg::pixel_t  pix_data,
    input  wire logic              k_we,
    input  wire logic [3:0]        k_idx,
    input  wire conv_pkg::weight_t k_data,
    input  wire logic              start,
    output logic                   busy,
    output logic                   done,
    input  wire logic [res_aw-1:0] res_addr,
    output conv_pkg::acc_t         res_data
);

    conv_pkg::kernel_t  kernel;
    conv_pkg::tap_req_t req;
    conv_pkg::mac_op_t  op;
    conv_pkg::acc_out_t acc;

    kernel_regs u_kernel_regs (
        .clk    (clk),
        .rst    (rst),
        .k_we   (k_we),
        .k_idx  (k_idx),
        .k_data (k_data),
        .busy   (busy),
        .kernel (kernel)
    );

    conv_ctrl #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_conv_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .busy  (busy)
    );

    window_store #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_window_store (
        .clk      (clk),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .kernel   (kernel),
        .req      (req),
        .op       (op)
    );

    mac_pipe u_mac_pipe (
        .clk (clk),
        .rst (rst),
        .op  (op),
        .acc (acc)
    );

    result_store #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_result_store (
        .clk      (clk),
        .rst      (rst),
        .start    (start && !busy),  // only a start the sequencer accepts
        .acc      (acc),
        .res_addr (res_addr),
        .res_data (res_data),
        .done     (done)
    );

endmodule

`default_nettype wire

//--- hw/kernel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_regs (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              k_we,
    input  wire logic [3:0]        k_idx,
    input  wire conv_pkg::weight_t k_data,
    input  wire logic              busy,    // only used by the check below
    output conv_pkg::kernel_t      kernel
);

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel <= '0;
        end else if (k_we && (k_idx < conv_pkg::KTAPS)) begin  // out of range index dropped
            kernel[k_idx] <= k_data;
        end
    end

    // the window store reads the weights live, so a write during a run
    // would mix two kernels into one result set
    a_no_write_while_busy : assert property (
        @(posedge clk) disable iff (rst)
        !(k_we && busy)
    ) else $error("kernel written while the engine is busy");

endmodule

`default_nettype wire

//--- hw/mac_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pipe (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire conv_pkg::mac_op_t op,
    output conv_pkg::acc_out_t     acc
);

    logic           s1_valid;
    logic           s1_first;
    logic           s1_last;
    conv_pkg::acc_t s1_prod;
    conv_pkg::acc_t sum_next;

    // stage one, product only
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= op.valid;
        end
        s1_first <= op.first;
        s1_last  <= op.last;
        s1_prod  <= op.pixel * op.weight;  // low 32 bits kept
    end

    // first tap reloads, so windows can follow back to back
    assign sum_next = s1_first ? s1_prod : acc.sum + s1_prod;

    // stage two, acc.sum doubles as the running total
    always_ff @(posedge clk) begin
        if (rst) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= s1_valid && s1_last;  // one pulse per window
        end
        if (s1_valid) begin
            acc.sum <= sum_next;
        end
    end

    // a window is exactly nine consecutive taps, first to last
    a_window_shape : assert property (
        @(posedge clk) disable iff (rst)
        (op.valid && op.first) |-> ##1 (op.valid && !op.first && !op.last) [*7]
                                   ##1 (op.valid && op.last)
    ) else $error("window taps not contiguous or wrong length");

endmodule

`default_nettype wire

//--- hw/result_store.sv
`timescale 1ns/1ps
`default_nettype none

module result_store #(
    parameter  int img_width  = 8,
    parameter  int img_height = 8,
    localparam int n_res      = (img_width - 2) * (img_height - 2),
    localparam int res_aw     = $clog2(n_res)
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire conv_pkg::acc_out_t acc,
    input  wire logic [res_aw-1:0]  res_addr,
    output conv_pkg::acc_t          res_data,
    output logic                    done
);

    conv_pkg::acc_t res_mem [n_res];  // row-major output positions

    logic [res_aw-1:0] wr_cnt;
    conv_pkg::acc_t    relu_val;

    assign relu_val = acc.sum[31] ? '0 : acc.sum;  // negatives clamp to zero

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
            done   <= 1'b0;
        end else if (start) begin
            wr_cnt <= '0;
            done   <= 1'b0;
        end else if (acc.valid) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == res_aw'(n_res - 1)) begin
                done <= 1'b1;  // last slot written this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc.valid) begin
            res_mem[wr_cnt] <= relu_val;
        end
    end

    assign res_data = res_mem[res_addr];  // combinational host read

    // more sums than slots means the sequencer and this counter disagree
    a_no_sum_after_done : assert property (
        @(posedge clk) disable iff (rst)
        done |-> !acc.valid
    ) else $error("result arrived after done");

endmodule

`default_nettype wire

//--- hw/window_store.sv
`timescale 1ns/1ps
`default_nettype none

module window_store #(
    parameter  int img_width  = 8,
    parameter  int img_height = 8,
    localparam int pix_aw     = $clog2(img_width * img_height)
) (
    input  wire logic               clk,
    input  wire logic               pix_we,
    input  wire logic [pix_aw-1:0]  pix_addr,   // row-major index
    input  wire conv_pkg::pixel_t   pix_data,
    input  wire conv_pkg::kernel_t  kernel,
    input  wire conv_pkg::tap_req_t req,
    output conv_pkg::mac_op_t       op
);

    conv_pkg::pixel_t tile [img_width * img_height];  // whole image tile

    logic [3:0]        tap_row;   // tap / 3
    logic [3:0]        tap_col;   // tap % 3
    logic [3:0]        pix_row;
    logic [3:0]        pix_col;
    logic [pix_aw-1:0] rd_addr;

    // host write port
    always_ff @(posedge clk) begin
        if (pix_we) begin
            tile[pix_addr] <= pix_data;
        end
    end

    // map the requested tap onto an image coordinate
    always_comb begin
        tap_row = req.tap / 4'd3;
        tap_col = req.tap % 4'd3;
        pix_row = req.row + tap_row;
        pix_col = req.col + tap_col;
        rd_addr = pix_aw'(pix_row * img_width + pix_col);
    end

    // one cycle from request to operand pair, tags ride along
    always_ff @(posedge clk) begin
        op.valid  <= req.valid;
        op.first  <= req.first;
        op.last   <= req.last;
        op.pixel  <= tile[rd_addr];
        op.weight <= kernel[req.tap];
    end

    a_tap_in_range : assert property (
        @(posedge clk)
        req.valid |-> (req.tap < conv_pkg::KTAPS)
    ) else $error("tap request %0d out of range", req.tap);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_conv_top -f compile.f -o tb_conv_top

sim_out=$(./obj_dir/tb_conv_top)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK"

//--- test/conv_tb_model.svh
`ifndef CONV_TB_MODEL_SVH
`define CONV_TB_MODEL_SVH

conv_pkg::pixel_t  img_mem  [img_w * img_h];  // image as last written to the DUT
conv_pkg::weight_t kern_mem [9];              // kernel as last written, row-major

// 3x3 sum at output slot idx with 32-bit wrap, then ReLU
function automatic conv_pkg::acc_t ref_conv(input int idx);
    int             r;
    int             c;
    conv_pkg::acc_t sum;
    r   = idx / (img_w - 2);
    c   = idx % (img_w - 2);
    sum = '0;
    for (int t = 0; t < 9; t++) begin
        sum = sum + img_mem[(r + t / 3) * img_w + c + t % 3] * kern_mem[t];
    end
    return (sum < 0) ? '0 : sum;
endfunction

task automatic write_image();
    for (int a = 0; a < img_w * img_h; a++) begin
        @(negedge clk);
        pix_we   = 1'b1;
        pix_addr = pix_aw'(a);
        pix_data = img_mem[a];
    end
    @(negedge clk);
    pix_we = 1'b0;
endtask

task automatic write_kernel();
    for (int t = 0; t < 9; t++) begin
        @(negedge clk);
        k_we   = 1'b1;
        k_idx  = 4'(t);
        k_data = kern_mem[t];
    end
    @(negedge clk);
    k_we = 1'b0;
endtask

// pulse start, optionally poke start again mid-run, then wait for done
task automatic run_and_wait(input bit poke_while_busy);
    int waited;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    n_checks++;
    assert (busy && !done) else begin
        $display("busy did not rise or done did not fall after start");
        n_errors++;
    end
    if (poke_while_busy) begin
        repeat (n_res * 4) @(negedge clk);  // some results are already stored by now
        n_checks++;
        assert (busy) else begin
            $display("engine was no longer busy when start was pulsed again");
            n_errors++;
        end
        start = 1'b1;  // the engine is busy, so this must have no effect
        @(negedge clk);
        start = 1'b0;
    end
    waited = 0;
    while (!done && waited < done_limit) begin
        @(negedge clk);
        waited++;
    end
    if (!done) begin
        $display("done never rose within %0d cycles", done_limit);
        n_errors++;
        aborted = 1'b1;
    end else begin
        n_checks++;
        assert (!busy) else begin
            $display("busy still high while done is high");
            n_errors++;
        end
    end
endtask

`endif

//--- test/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;

    localparam int img_w      = 8;
    localparam int img_h      = 8;
    localparam int n_res      = (img_w - 2) * (img_h - 2);
    localparam int pix_aw     = $clog2(img_w * img_h);
    localparam int res_aw     = $clog2(n_res);
    localparam int done_limit = 2000;  // a run needs about n_res * 9 cycles

    logic              clk;
    logic              rst;
    logic              pix_we;
    logic [pix_aw-1:0] pix_addr;
    conv_pkg::pixel_t  pix_data;
    logic              k_we;
    logic [3:0]        k_idx;
    conv_pkg::weight_t k_data;
    logic              start;
    logic              busy;
    logic              done;
    logic [res_aw-1:0] res_addr;
    conv_pkg::acc_t    res_data;

    integer seed = 10638;
    int     n_checks = 0;
    int     n_errors = 0;
    bit     aborted = 1'b0;  // set when a wait timed out

    conv_top #(
        .img_width  (img_w),
        .img_height (img_h)
    ) u_conv_top (
        .clk      (clk),
        .rst      (rst),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .k_we     (k_we),
        .k_idx    (k_idx),
        .k_data   (k_data),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .res_addr (res_addr),
        .res_data (res_data)
    );

    `include "conv_tb_model.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // read back every slot and compare with the model
    task automatic check_results(input string name);
        conv_pkg::acc_t expected;
        for (int i = 0; i < n_res; i++) begin
            @(negedge clk);
            res_addr = res_aw'(i);
            expected = ref_conv(i);
            @(posedge clk);
            n_checks++;
            assert (res_data == expected) else begin
                $display("MISMATCH %s slot %0d expected %0d actual %0d",
                         name, i, expected, res_data);
                n_errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished with %0d errors", name, n_errors - errs_before);
    endtask

    task automatic test_idle(input string name);
        int errs_before;
        errs_before = n_errors;
        n_checks++;
        assert (!busy && !done) else begin
            $display("busy or done high after reset");
            n_errors++;
        end
        for (int a = 0; a < img_w * img_h; a++) begin
            img_mem[a] = $random(seed) & 32'h0000_ffff;  // non-negative
        end
        for (int t = 0; t < 9; t++) begin
            kern_mem[t] = (t == 4) ? 1 : 0;  // identity
        end
        write_image();
        write_kernel();
        repeat (20) begin
            @(negedge clk);
            n_checks++;
            assert (!done) else begin
                $display("done rose without a start");
                n_errors++;
            end
        end
        report_test(name, errs_before);
    endtask

    task automatic test_conv(input string name, input bit poke_while_busy);
        int errs_before;
        errs_before = n_errors;
        run_and_wait(poke_while_busy);
        if (!aborted) begin
            check_results(name);
        end
        report_test(name, errs_before);
    endtask

    task automatic load_ramp(input bit reversed);
        for (int a = 0; a < img_w * img_h; a++) begin
            img_mem[a] = reversed ? (img_h - 1 - a / img_w) * 5 : (a / img_w) * 5;
        end
        for (int t = 0; t < 9; t++) begin
            kern_mem[t] = (t < 3) ? -1 : ((t < 6) ? 0 : 1);  // vertical edge
        end
        write_image();
        write_kernel();
    endtask

    task automatic end_of_run();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        rst      = 1'b1;
        pix_we   = 1'b0;
        pix_addr = '0;
        pix_data = '0;
        k_we     = 1'b0;
        k_idx    = '0;
        k_data   = '0;
        start    = 1'b0;
        res_addr = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_idle("idle_after_reset");
        if (!aborted) begin
            test_conv("identity", 1'b0);
        end
        if (!aborted) begin
            load_ramp(1'b0);
            test_conv("ramp_up", 1'b0);
        end
        if (!aborted) begin
            load_ramp(1'b1);
            test_conv("ramp_down_relu", 1'b0);  // all results clamp to zero
        end
        if (!aborted) begin
            for (int a = 0; a < img_w * img_h; a++) begin
                img_mem[a] = $random(seed);
            end
            for (int t = 0; t < 9; t++) begin
                kern_mem[t] = $random(seed);
            end
            write_image();
            write_kernel();
            test_conv("random_signed", 1'b0);
        end
        if (!aborted) begin
            for (int t = 0; t < 9; t++) begin
                kern_mem[t] = $random(seed) % 100;  // new kernel, same image
            end
            write_kernel();
            test_conv("back_to_back_start_while_busy", 1'b1);
        end
        end_of_run();
    end

endmodule

`default_nettype wire
